// File: rtl/bridge_pkg.sv
package bridge_pkg;

    localparam int BYTE_W = 8;                  // Width of every data byte path
    localparam int LED_W  = 6;                  // Six board LEDs

    typedef logic [BYTE_W-1:0] byte_t;          // Data byte on SPI, UART and FIFOs
    typedef logic [LED_W-1:0]  led_t;           // LED output vector

    // Simulation values, a board build raises these two
    localparam int CLKS_PER_BIT    = 16;        // Clock cycles per UART bit
    localparam int LED_STEP_CYCLES = 64;        // Clock cycles between LED shifts

    localparam int HALF_BIT   = CLKS_PER_BIT / 2;   // Offset from start edge to mid-bit
    localparam int FIFO_DEPTH = 8;                  // Default byte_fifo depth, power of two

    localparam led_t LED_RESET_PATTERN = led_t'(1); // Lowest LED lit after reset

    typedef logic [$clog2(CLKS_PER_BIT)-1:0]    baud_cnt_t;  // Cycle count within one bit
    typedef logic [$clog2(LED_STEP_CYCLES)-1:0] step_cnt_t;  // Cycle count between LED steps
    typedef logic [2:0]                         bit_idx_t;   // Bit index inside a byte

    typedef enum logic [1:0] {
        IDLE,                                   // Line idle, waiting for work
        START,                                  // Start bit
        DATA,                                   // Eight data bits, LSB first
        STOP                                    // Single stop bit
    } uart_state_e;

endpackage

// File: rtl/byte_fifo.sv
module byte_fifo #(
    parameter int DEPTH = bridge_pkg::FIFO_DEPTH    // Must be a power of two
) (
    input  logic              Clock,
    input  logic              arst_n,
    input  logic              push,
    input  logic              pop,
    input  bridge_pkg::byte_t din,
    output bridge_pkg::byte_t dout,
    output logic              empty,
    output logic              full
);
    import bridge_pkg::*;

    byte_t                    mem [DEPTH];      // Storage, no reset needed
    logic [$clog2(DEPTH)-1:0] wr_ptr;           // Next slot to write
    logic [$clog2(DEPTH)-1:0] rd_ptr;           // Current head slot
    logic [$clog2(DEPTH):0]   count;            // Occupancy, one bit wider than pointers
    logic                     do_push;
    logic                     do_pop;

    assign do_push = push && !full;             // Push into a full FIFO is dropped
    assign do_pop  = pop && !empty;             // Pop from an empty FIFO is ignored
    assign empty   = (count == 0);
    assign full    = (count == DEPTH);
    assign dout    = mem[rd_ptr];               // Fall-through head

    always_ff @(posedge Clock) begin
        if (do_push) mem[wr_ptr] <= din;
    end

    always_ff @(posedge Clock or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) wr_ptr <= wr_ptr + 1'b1;   // Wraps at DEPTH
            if (do_pop)  rd_ptr <= rd_ptr + 1'b1;
            count <= count + do_push - do_pop;      // Both at once leaves count as is
        end
    end

    a_no_overflow: assert property (@(posedge Clock) disable iff (!arst_n) !(push && full))
        else $error("byte_fifo push while full, byte dropped");
    a_no_underflow: assert property (@(posedge Clock) disable iff (!arst_n) !(pop && empty))
        else $error("byte_fifo pop while empty");

endmodule

// File: rtl/spi_slave.sv
module spi_slave (
    input  logic              Clock,
    input  logic              arst_n,
    input  logic              sck,
    input  logic              cs_n,
    input  logic              mosi,
    input  logic              ack,
    output logic              miso,
    output logic              ready,
    output bridge_pkg::byte_t rx_byte
);
    import bridge_pkg::*;

    logic [1:0] sck_sync;                       // Two-flop synchronisers, [1] is safe
    logic [1:0] cs_sync;
    logic [1:0] mosi_sync;
    logic       sck_prev;                       // Last synchronised SCK level
    logic       rise;                           // Registered SCK rising edge
    logic       fall;                           // Registered SCK falling edge
    bit_idx_t   bit_cnt;                        // Bits received in the current byte
    byte_t      rx_shift;                       // MOSI shift register
    byte_t      tx_shift;                       // MISO shift register, MSB out
    byte_t      reply;                          // Last complete byte, also the echo
    logic       done;                           // Eighth bit just shifted in

    assign miso    = tx_shift[BYTE_W-1];
    assign rx_byte = reply;

    always_ff @(posedge Clock or negedge arst_n) begin
        if (!arst_n) begin
            sck_sync  <= '0;                    // SCK idles low in mode 0
            cs_sync   <= '1;                    // Deselected
            mosi_sync <= '0;
            sck_prev  <= 1'b0;
            rise      <= 1'b0;
            fall      <= 1'b0;
        end else begin
            sck_sync  <= {sck_sync[0], sck};
            cs_sync   <= {cs_sync[0], cs_n};
            mosi_sync <= {mosi_sync[0], mosi};
            sck_prev  <= sck_sync[1];
            rise      <= sck_sync[1] && !sck_prev && !cs_sync[1];
            fall      <= !sck_sync[1] && sck_prev && !cs_sync[1];
        end
    end

    always_ff @(posedge Clock or negedge arst_n) begin
        if (!arst_n) begin
            bit_cnt  <= '0;
            rx_shift <= '0;
            tx_shift <= '0;                     // MISO sends zero before any transfer
            reply    <= '0;
            done     <= 1'b0;
            ready    <= 1'b0;
        end else begin
            done <= 1'b0;
            if (cs_sync[1]) begin
                bit_cnt  <= '0;                 // Deselect aborts a partial byte
                tx_shift <= reply;              // Preload MSB before first SCK edge
            end else begin
                if (rise) begin
                    rx_shift <= {rx_shift[BYTE_W-2:0], mosi_sync[1]};
                    bit_cnt  <= bit_cnt + 1'b1;         // Wraps to zero after bit 7
                    done     <= (bit_cnt == 3'd7);
                end
                if (fall) begin
                    if (bit_cnt == '0) tx_shift <= reply;   // Next byte in a burst
                    else tx_shift <= {tx_shift[BYTE_W-2:0], 1'b0};
                end
            end
            if (done) begin
                reply <= rx_shift;              // Overwrites a byte still pending
                ready <= 1'b1;
            end else if (ack) begin
                ready <= 1'b0;                  // Drops the cycle after ack
            end
        end
    end

    a_ack_needs_ready: assert property (@(posedge Clock) disable iff (!arst_n) ack |-> ready)
        else $error("spi_slave ack seen without a pending byte");

endmodule

// File: rtl/uart_rx.sv
module uart_rx (
    input  logic              Clock,
    input  logic              arst_n,
    input  logic              rx,
    output bridge_pkg::byte_t data,
    output logic              valid
);
    import bridge_pkg::*;

    logic [1:0]  rx_sync;                       // Line synchroniser, idles high
    logic        rx_prev;                       // For falling edge detect
    uart_state_e state;
    baud_cnt_t   clk_cnt;                       // Cycles into the current bit
    bit_idx_t    bit_idx;                       // Data bit being sampled
    byte_t       shift;                         // Assembled byte, LSB first

    assign data = shift;                        // Stable while valid pulses

    always_ff @(posedge Clock or negedge arst_n) begin
        if (!arst_n) begin
            rx_sync <= '1;
            rx_prev <= 1'b1;
            state   <= IDLE;
            clk_cnt <= '0;
            bit_idx <= '0;
            shift   <= '0;
            valid   <= 1'b0;
        end else begin
            rx_sync <= {rx_sync[0], rx};
            rx_prev <= rx_sync[1];
            valid   <= 1'b0;
            clk_cnt <= clk_cnt + 1'b1;
            case (state)
                IDLE: begin
                    clk_cnt <= '0;
                    if (rx_prev && !rx_sync[1]) state <= START;     // Start edge
                end
                START: begin
                    if (clk_cnt == baud_cnt_t'(HALF_BIT - 1)) begin
                        clk_cnt <= '0;
                        bit_idx <= '0;
                        state   <= rx_sync[1] ? IDLE : DATA;        // Glitch goes back
                    end
                end
                DATA: begin
                    if (clk_cnt == baud_cnt_t'(CLKS_PER_BIT - 1)) begin
                        clk_cnt <= '0;
                        shift   <= {rx_sync[1], shift[BYTE_W-1:1]};
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) state <= STOP;
                    end
                end
                STOP: begin
                    if (clk_cnt == baud_cnt_t'(CLKS_PER_BIT - 1)) begin
                        valid <= rx_sync[1];    // Framing error drops the byte
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

// File: rtl/uart_tx.sv
module uart_tx (
    input  logic              Clock,
    input  logic              arst_n,
    input  logic              empty,
    input  bridge_pkg::byte_t data,
    output logic              pop,
    output logic              tx
);
    import bridge_pkg::*;

    uart_state_e state;
    baud_cnt_t   clk_cnt;                       // Cycles into the current bit
    bit_idx_t    bit_idx;                       // Data bit on the line
    byte_t       shift;                         // Byte being sent, LSB in bit 0

    assign pop = (state == IDLE) && !empty;     // Load the FIFO head when idle

    always_ff @(posedge Clock or negedge arst_n) begin
        if (!arst_n) begin
            state   <= IDLE;
            clk_cnt <= '0;
            bit_idx <= '0;
            shift   <= '0;
            tx      <= 1'b1;                    // Line idles high
        end else begin
            clk_cnt <= clk_cnt + 1'b1;
            case (state)
                IDLE: begin
                    clk_cnt <= '0;
                    if (pop) begin
                        shift <= data;
                        tx    <= 1'b0;          // Start bit from the next cycle
                        state <= START;
                    end
                end
                START: begin
                    if (clk_cnt == baud_cnt_t'(CLKS_PER_BIT - 1)) begin
                        clk_cnt <= '0;
                        bit_idx <= '0;
                        tx      <= shift[0];
                        state   <= DATA;
                    end
                end
                DATA: begin
                    if (clk_cnt == baud_cnt_t'(CLKS_PER_BIT - 1)) begin
                        clk_cnt <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        shift   <= shift >> 1;
                        if (bit_idx == 3'd7) begin
                            tx    <= 1'b1;      // Stop bit
                            state <= STOP;
                        end else begin
                            tx <= shift[1];
                        end
                    end
                end
                STOP: begin
                    if (clk_cnt == baud_cnt_t'(CLKS_PER_BIT - 1)) state <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

// File: rtl/echo_arbiter.sv
module echo_arbiter (
    input  logic              Clock,
    input  logic              arst_n,
    input  logic              spi_ready,
    input  logic              rx_empty,
    input  logic              tx_full,
    input  bridge_pkg::byte_t spi_byte,
    input  bridge_pkg::byte_t rx_head,
    output logic              spi_ack,
    output logic              rx_pop,
    output logic              tx_push,
    output bridge_pkg::byte_t tx_byte,
    output logic              debug_pin
);
    import bridge_pkg::*;

    logic busy;                                 // A strobe is in flight this cycle
    logic take_spi;
    logic take_rx;

    // SPI wins, the receive FIFO waits a turn
    assign take_spi = spi_ready && !tx_full && !busy;
    assign take_rx  = !rx_empty && !spi_ready && !tx_full && !busy;

    always_ff @(posedge Clock or negedge arst_n) begin
        if (!arst_n) begin
            spi_ack   <= 1'b0;
            rx_pop    <= 1'b0;
            tx_push   <= 1'b0;
            busy      <= 1'b0;
            debug_pin <= 1'b0;
        end else begin
            spi_ack <= take_spi;                // Ready drops one cycle later
            rx_pop  <= take_rx;                 // Head advances one cycle later
            tx_push <= take_spi || take_rx;
            busy    <= take_spi || take_rx;     // Blocks the stale request
            if (take_spi) debug_pin <= !debug_pin;  // One toggle per SPI byte
        end
    end

    always_ff @(posedge Clock) begin
        if (take_spi) tx_byte <= spi_byte;
        else if (take_rx) tx_byte <= rx_head;
    end

endmodule

// File: rtl/led_scroll.sv
module led_scroll (
    input  logic             Clock,
    input  logic             arst_n,
    output bridge_pkg::led_t leds
);
    import bridge_pkg::*;

    step_cnt_t step_cnt;                        // Cycles since the last shift

    always_ff @(posedge Clock or negedge arst_n) begin
        if (!arst_n) begin
            step_cnt <= '0;
            leds     <= LED_RESET_PATTERN;
        end else begin
            if (step_cnt == step_cnt_t'(LED_STEP_CYCLES - 1)) begin
                step_cnt <= '0;
                leds     <= {leds[LED_W-2:0], leds[LED_W-1]};  // Rotate left, top wraps
            end else begin
                step_cnt <= step_cnt + 1'b1;
            end
        end
    end

endmodule

// File: rtl/bridge_top.sv
module bridge_top (
    input  logic             Clock,
    input  logic             arst_n,
    input  logic             spi_sck,
    input  logic             spi_cs_n,
    input  logic             spi_mosi,
    input  logic             uart_rx,
    output logic             spi_miso,
    output logic             uart_tx,
    output bridge_pkg::led_t leds,
    output logic             debug_pin
);
    import bridge_pkg::*;

    byte_t spi_byte;                            // SPI slave to arbiter
    logic  spi_ready;
    logic  spi_ack;
    byte_t rx_byte;                             // UART receiver to its FIFO
    logic  rx_valid;
    byte_t rx_head;                             // Receive FIFO to arbiter
    logic  rx_empty;
    logic  rx_pop;
    byte_t tx_byte;                             // Arbiter to transmit FIFO
    logic  tx_push;
    logic  tx_full;
    byte_t tx_head;                             // Transmit FIFO to UART transmitter
    logic  tx_empty;
    logic  tx_pop;

    spi_slave u_spi (
        .Clock(Clock), .arst_n(arst_n), .sck(spi_sck), .cs_n(spi_cs_n), .mosi(spi_mosi),
        .ack(spi_ack), .miso(spi_miso), .ready(spi_ready), .rx_byte(spi_byte)
    );

    uart_rx u_uart_rx (
        .Clock(Clock), .arst_n(arst_n), .rx(uart_rx), .data(rx_byte), .valid(rx_valid)
    );

    byte_fifo #(.DEPTH(FIFO_DEPTH)) rx_fifo (   // Full flag unused, arbiter drains fast
        .Clock(Clock), .arst_n(arst_n), .push(rx_valid), .pop(rx_pop), .din(rx_byte),
        .dout(rx_head), .empty(rx_empty), .full()
    );

    echo_arbiter u_arbiter (
        .Clock(Clock), .arst_n(arst_n), .spi_ready(spi_ready), .rx_empty(rx_empty),
        .tx_full(tx_full), .spi_byte(spi_byte), .rx_head(rx_head), .spi_ack(spi_ack),
        .rx_pop(rx_pop), .tx_push(tx_push), .tx_byte(tx_byte), .debug_pin(debug_pin)
    );

    byte_fifo #(.DEPTH(FIFO_DEPTH)) tx_fifo (
        .Clock(Clock), .arst_n(arst_n), .push(tx_push), .pop(tx_pop), .din(tx_byte),
        .dout(tx_head), .empty(tx_empty), .full(tx_full)
    );

    uart_tx u_uart_tx (
        .Clock(Clock), .arst_n(arst_n), .empty(tx_empty), .data(tx_head), .pop(tx_pop),
        .tx(uart_tx)
    );

    led_scroll u_leds (
        .Clock(Clock), .arst_n(arst_n), .leds(leds)
    );

endmodule

// File: testbench/tb_clock.sv
module tb_clock #(
    parameter int PERIOD = 20                   // Clock period in time units
) (
    output logic Clock
);
    initial begin
        Clock = 1'b0;
        forever #(PERIOD / 2) Clock = ~Clock;
    end
endmodule

// File: testbench/bridge_checker.sv
module bridge_checker (
    input  logic             Clock,
    input  logic             arst_n,
    input  logic             spi_sck,
    input  logic             spi_cs_n,
    input  logic             spi_miso,
    input  logic             uart_tx,
    input  bridge_pkg::led_t leds,
    input  logic             debug_pin,
    output int               echo_count
);
    import bridge_pkg::*;

    localparam int MID = CLKS_PER_BIT / 2;      // Start edge to mid-bit

    byte_t echo_q[$];                           // Bytes still due on uart_tx
    byte_t miso_q[$];                           // One reply per SPI transfer
    int    errs[4] = '{default: 0};             // uart_tx, spi_miso, debug_pin, leds
    int    spi_count = 0;                       // SPI bytes sent in so far
    int    toggles = 0;
    logic  debug_prev = 1'b0;
    int    frame_cnt = 0;                       // Cycles into a uart_tx frame or 0 when idle
    int    bit_no;
    byte_t frame_byte;
    byte_t miso_byte;
    int    miso_bits = 0;
    int    led_cycles = 0;                      // Rising edges since reset release
    led_t  exp_leds;

    initial echo_count = 0;

    function automatic void push_echo(input byte_t value);
        echo_q.push_back(value);
    endfunction

    function automatic void push_miso(input byte_t value);
        miso_q.push_back(value);
        spi_count++;
    endfunction

    function automatic int total_errors();
        return errs[0] + errs[1] + errs[2] + errs[3];
    endfunction

    function automatic led_t rotate_left(input led_t p, input int n);
        led_t r;
        r = p;
        for (int i = 0; i < n; i++) r = {r[$bits(led_t)-2:0], r[$bits(led_t)-1]};
        return r;
    endfunction

    task automatic print_counts();
        $display("Errors uart_tx=%0d spi_miso=%0d debug_pin=%0d leds=%0d total=%0d",
                 errs[0], errs[1], errs[2], errs[3], total_errors());
    endtask

    task automatic value_error(input int cat, input string sig, input int exp, input int act);
        $display("[ERROR] %0t %s expected %0h actual %0h", $time, sig, exp, act);
        errs[cat]++;
    endtask

    task automatic plain_error(input int cat, input string msg);
        $display("At time %0t %s", $time, msg);
        errs[cat]++;
    endtask

    // One debug_pin toggle per SPI byte and none for UART bytes
    task automatic check_toggles();
        if (toggles != spi_count) value_error(2, "debug_pin toggles", spi_count, toggles);
    endtask

    task automatic check_frame();
        byte_t expected;
        if (uart_tx !== 1'b1) plain_error(0, "the uart_tx stop bit was low");
        else if (echo_q.size() == 0) plain_error(0, "uart_tx sent a byte nobody sent in");
        else begin
            expected = echo_q.pop_front();
            if (frame_byte !== expected) value_error(0, "uart_tx", expected, frame_byte);
        end
        check_toggles();
        echo_count++;
    endtask

    // Reset values, LED rotation and debug toggles sampled on the falling edge
    always @(negedge Clock) begin
        if (!arst_n) begin
            led_cycles = 0;
            if (uart_tx !== 1'b1) value_error(0, "uart_tx", 1, uart_tx);
            if (leds !== LED_RESET_PATTERN) value_error(3, "leds", LED_RESET_PATTERN, leds);
            if (spi_miso !== 1'b0) value_error(1, "spi_miso", 0, spi_miso);
            if (debug_pin !== 1'b0) value_error(2, "debug_pin", 0, debug_pin);
        end else begin
            exp_leds = rotate_left(LED_RESET_PATTERN,
                                   (led_cycles / LED_STEP_CYCLES) % $bits(led_t));
            if ($countones(leds) != 1) plain_error(3, "leds does not have exactly one bit set");
            else if (leds !== exp_leds) value_error(3, "leds", exp_leds, leds);
            led_cycles++;
            if (debug_pin !== debug_prev) toggles++;
        end
        debug_prev = debug_pin;
    end

    // uart_tx frame decoder
    always @(negedge Clock) begin
        if (!arst_n) begin
            frame_cnt = 0;
        end else if (frame_cnt == 0) begin
            if (uart_tx === 1'b0) frame_cnt = 1;    // Start edge seen half a cycle in
        end else begin
            frame_cnt++;
            if ((frame_cnt - MID) % CLKS_PER_BIT == 0) begin
                bit_no = (frame_cnt - MID) / CLKS_PER_BIT;  // 0 start, 1 to 8 data, 9 stop
                if (bit_no == 0 && uart_tx !== 1'b0) begin
                    plain_error(0, "the uart_tx start bit ended before mid-bit");
                    frame_cnt = 0;
                end else if (bit_no >= 1 && bit_no <= 8) begin
                    frame_byte[bit_no - 1] = uart_tx;       // LSB first
                end else if (bit_no == 9) begin
                    frame_cnt = 0;
                    check_frame();
                end
            end
        end
    end

    always @(posedge spi_sck) begin
        if (arst_n && !spi_cs_n) begin
            miso_byte = {miso_byte[6:0], spi_miso};         // MSB first
            miso_bits++;
        end
    end

    always @(posedge spi_cs_n) begin
        if (arst_n && miso_bits != 0) begin
            if (miso_bits != 8) plain_error(1, "an SPI transfer did not carry eight bits");
            else if (miso_q.size() == 0) plain_error(1, "an SPI transfer had no reply due");
            else begin
                if (miso_byte !== miso_q[0]) value_error(1, "spi_miso", miso_q[0], miso_byte);
                void'(miso_q.pop_front());
            end
        end
        miso_bits = 0;
    end

endmodule

// File: testbench/tb_bridge.sv
module tb_bridge;
    import bridge_pkg::*;

    localparam int DRIVE_DELAY  = 2;            // Inputs change this long after the edge
    localparam int RESET_CYCLES = 16;
    localparam int SPI_HALF     = 8;            // Clocks per SCK half period
    localparam int ECHO_TIMEOUT = 20 * 10 * CLKS_PER_BIT;  // About twenty UART frames

    logic       Clock;
    logic       arst_n;
    logic       spi_sck;
    logic       spi_cs_n;
    logic       spi_mosi;
    logic       uart_rx;
    logic       spi_miso;
    logic       uart_tx;
    led_t       leds;
    logic       debug_pin;
    int         echo_count;                     // Frames decoded by the checker
    int         sent_count = 0;                 // Bytes sent in that each owe one echo
    logic       run_failed = 1'b0;
    int         fd;
    string      line;
    logic [7:0] kind;
    byte_t      data;
    byte_t      echo;
    byte_t      miso;

    tb_clock #(.PERIOD(20)) clk_gen (.Clock(Clock));

    bridge_top UUT (
        .Clock(Clock), .arst_n(arst_n), .spi_sck(spi_sck), .spi_cs_n(spi_cs_n),
        .spi_mosi(spi_mosi), .uart_rx(uart_rx), .spi_miso(spi_miso), .uart_tx(uart_tx),
        .leds(leds), .debug_pin(debug_pin)
    );

    bridge_checker chk (
        .Clock(Clock), .arst_n(arst_n), .spi_sck(spi_sck), .spi_cs_n(spi_cs_n),
        .spi_miso(spi_miso), .uart_tx(uart_tx), .leds(leds), .debug_pin(debug_pin),
        .echo_count(echo_count)
    );

    task automatic after_edges(input int n);
        repeat (n) @(posedge Clock);
        #DRIVE_DELAY;
    endtask

    task automatic spi_transfer(input byte_t value);
        spi_cs_n = 1'b0;
        after_edges(SPI_HALF);
        for (int i = BYTE_W - 1; i >= 0; i--) begin
            spi_mosi = value[i];                // Mode 0 data changes while SCK is low
            after_edges(SPI_HALF);
            spi_sck = 1'b1;
            after_edges(SPI_HALF);
            spi_sck = 1'b0;
        end
        after_edges(SPI_HALF);
        spi_cs_n = 1'b1;
        after_edges(SPI_HALF);
    endtask

    task automatic uart_send(input byte_t value);
        uart_rx = 1'b0;                         // Start bit
        after_edges(CLKS_PER_BIT);
        for (int i = 0; i < BYTE_W; i++) begin
            uart_rx = value[i];
            after_edges(CLKS_PER_BIT);
        end
        uart_rx = 1'b1;                         // Stop bit then idle line
        after_edges(CLKS_PER_BIT);
    endtask

    task automatic wait_echoes();
        int waited;
        waited = 0;
        while (echo_count != sent_count && waited < ECHO_TIMEOUT) begin
            @(posedge Clock);
            waited++;
        end
        if (echo_count != sent_count) begin
            $display("Timed out after %0d cycles with %0d of %0d echoes seen on uart_tx",
                     waited, echo_count, sent_count);
            run_failed = 1'b1;
        end
        if (waited > 0) #DRIVE_DELAY;
    endtask

    task automatic run_case(input logic [7:0] k, input byte_t value, input byte_t exp_echo,
                            input byte_t exp_miso);
        if (k != "B") wait_echoes();            // Burst bytes go back to back
        if (!run_failed) begin
            case (k)
                "S": begin
                    chk.push_miso(exp_miso);
                    chk.push_echo(exp_echo);
                    sent_count++;
                    spi_transfer(value);
                end
                "U", "B": begin
                    chk.push_echo(exp_echo);
                    sent_count++;
                    uart_send(value);
                end
                "G": after_edges(int'(value));
                default: begin
                    $display("Unknown case kind %c in the cases file", k);
                    run_failed = 1'b1;
                end
            endcase
        end
    endtask

    initial begin
        arst_n   = 1'b1;
        spi_sck  = 1'b0;
        spi_cs_n = 1'b1;
        spi_mosi = 1'b0;
        uart_rx  = 1'b1;
        #1 arst_n = 1'b0;
        after_edges(RESET_CYCLES);
        arst_n = 1'b1;
        after_edges(4);
        fd = $fopen("testbench/bridge_cases.txt", "r");
        if (fd == 0) begin
            $display("Could not open testbench/bridge_cases.txt");
            run_failed = 1'b1;
        end
        while (fd != 0 && !run_failed && !$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if ($sscanf(line, "%c %h %h %h", kind, data, echo, miso) == 4) begin
                run_case(kind, data, echo, miso);   // Comment lines fail the scan
            end
        end
        if (fd != 0) $fclose(fd);
        if (!run_failed) wait_echoes();
        chk.check_toggles();                    // Catches a stray toggle after the last frame
        chk.print_counts();
        if (run_failed || chk.total_errors() != 0 || sent_count == 0) begin
            $display("Result: FAILED");
        end else begin
            $display("Result: PASSED");
        end
        $finish;
    end

endmodule

// File: testbench/bridge_cases.txt
# kind data echo miso, kinds S spi, U uart, B uart burst, G gap
# gap lines idle for data clock cycles, unused columns hold 00
S a5 a5 00
S 3c 3c a5
U 5a 5a 00
S ff ff 3c
B 01 01 00
B 80 80 00
B 7e 7e 00
B c3 c3 00
G 40 00 00
S 00 00 ff
U 96 96 00
S 69 69 00
G 80 00 00

// File: filelist.f
rtl/bridge_pkg.sv
rtl/byte_fifo.sv
rtl/spi_slave.sv
rtl/uart_rx.sv
rtl/uart_tx.sv
rtl/echo_arbiter.sv
rtl/led_scroll.sv
rtl/bridge_top.sv
testbench/tb_clock.sv
testbench/bridge_checker.sv
testbench/tb_bridge.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_bridge
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := Result: PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator, run it and check the result"
	@echo "  clean  remove the Verilator build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
